// ==== logic/lbm_pkg.sv ====
`default_nettype none

package lbm_pkg;

    // ------------------------------------------------------------
    // Number format
    // ------------------------------------------------------------
    localparam int FRAC_BITS = 13;

    // Q3.13 value and the raw product of two of them
    typedef logic signed [15:0] q_t;
    typedef logic signed [31:0] wide_t;

    // D2Q9 direction order, also the index into a population vector
    typedef enum logic [3:0] {
        D_NULL, D_N, D_NE, D_E, D_SE, D_S, D_SW, D_W, D_NW
    } dir_e;

    localparam int NUM_DIR = 9;

    typedef q_t [NUM_DIR-1:0] pop_vec_t;

    // Diagonal directions ne, se, sw and nw
    localparam logic [NUM_DIR-1:0] DIAG_MASK = 9'b1_0101_0100;

    // ------------------------------------------------------------
    // Fixed-point constants
    // ------------------------------------------------------------
    localparam q_t Q_ONE           = 16'sh2000;
    localparam q_t Q_TWO           = 16'sh4000;
    localparam q_t Q_THREE         = 16'sh6000;
    localparam q_t Q_THREE_HALVES  = 16'sh3000;
    localparam q_t Q_NINE_QUARTERS = 16'sh4800;

    // Lattice weights 4/9, 1/9 and 1/36
    localparam q_t W_NULL = 16'sh0e39;
    localparam q_t W_SIDE = 16'sh038e;
    localparam q_t W_DIAG = 16'sh00e4;

    // Stage latencies in clock cycles
    localparam int LAT_MOMENTS     = 2;
    localparam int LAT_VELOCITY    = 6;
    localparam int LAT_EQUILIBRIUM = 7;
    localparam int LAT_RELAX       = 2;
    localparam int LAT_TOTAL       = LAT_MOMENTS + LAT_VELOCITY + LAT_EQUILIBRIUM + LAT_RELAX;

    // Q3.13 multiply, result truncated toward minus infinity
    function automatic q_t q_mul(input q_t a, input q_t b);
        wide_t p;
        p = wide_t'(a) * wide_t'(b);
        return q_t'(p >>> FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

// ==== logic/lbm_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbm_delay #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== logic/lbm_moments.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbm_moments
    import lbm_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  pop_vec_t f_in,
    output q_t       rho_m,
    output wide_t    mom_x,
    output wide_t    mom_y,
    output pop_vec_t f_m
);

    // Input latch
    q_t f_l [NUM_DIR];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int d = 0; d < NUM_DIR; d++) begin
                f_l[d] <= '0;
            end
            f_m   <= '0;
            rho_m <= '0;
            mom_x <= '0;
            mom_y <= '0;
        end else begin
            for (int d = 0; d < NUM_DIR; d++) begin
                f_l[d] <= f_in[d];
                f_m[d] <= f_l[d];
            end

            // Density wraps at 16 bits
            rho_m <= f_l[D_NULL] + f_l[D_N] + f_l[D_NE] + f_l[D_E] + f_l[D_SE]
                   + f_l[D_S] + f_l[D_SW] + f_l[D_W] + f_l[D_NW];

            // Momentum carried in Q.26 for the reciprocal multiply
            mom_x <= (f_l[D_E] - f_l[D_W] + f_l[D_NE] - f_l[D_SW] - f_l[D_NW] + f_l[D_SE])
                     <<< FRAC_BITS;
            mom_y <= (f_l[D_N] - f_l[D_S] + f_l[D_NE] - f_l[D_SW] + f_l[D_NW] - f_l[D_SE])
                     <<< FRAC_BITS;
        end
    end

endmodule

`default_nettype wire

// ==== logic/lbm_velocity.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbm_velocity
    import lbm_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  q_t    rho_m,
    input  wide_t mom_x,
    input  wide_t mom_y,
    output q_t    u_x_v,
    output q_t    u_y_v
);

    // Newton-Raphson iterates for 1/rho, seed 1.0
    q_t x1;
    q_t x2;
    q_t x2_h;
    q_t x3;
    q_t rx2;
    q_t rho_p1;
    q_t rho_p2;

    // Momentum follows its own item down the first four stages
    wide_t mx_p [4];
    wide_t my_p [4];
    wide_t px;
    wide_t py;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x1     <= '0;
            x2     <= '0;
            x2_h   <= '0;
            x3     <= '0;
            rx2    <= '0;
            rho_p1 <= '0;
            rho_p2 <= '0;
            for (int i = 0; i < 4; i++) begin
                mx_p[i] <= '0;
                my_p[i] <= '0;
            end
            px    <= '0;
            py    <= '0;
            u_x_v <= '0;
            u_y_v <= '0;
        end else begin
            mx_p[0] <= mom_x;
            my_p[0] <= mom_y;
            for (int i = 1; i < 4; i++) begin
                mx_p[i] <= mx_p[i-1];
                my_p[i] <= my_p[i-1];
            end

            // x1 = 2 - rho is the first step from x0 = 1
            x1     <= Q_TWO - rho_m;
            rho_p1 <= rho_m;

            x2     <= q_mul(x1, Q_TWO - q_mul(rho_p1, x1));
            rho_p2 <= rho_p1;

            rx2  <= q_mul(rho_p2, x2);
            x2_h <= x2;

            x3 <= q_mul(x2_h, Q_TWO - rx2);

            // Q3.13 momentum times Q3.13 reciprocal
            px <= (mx_p[3] >>> FRAC_BITS) * x3;
            py <= (my_p[3] >>> FRAC_BITS) * x3;

            u_x_v <= q_t'(px >>> FRAC_BITS);
            u_y_v <= q_t'(py >>> FRAC_BITS);
        end
    end

endmodule

`default_nettype wire

// ==== logic/lbm_equilibrium.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbm_equilibrium
    import lbm_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  q_t       u_x_v,
    input  q_t       u_y_v,
    output pop_vec_t f_eq
);

    // Per-direction pipeline, one array per stage
    q_t proj [NUM_DIR];
    q_t sq   [NUM_DIR];
    q_t pj2  [NUM_DIR];
    q_t a3   [NUM_DIR];
    q_t b9   [NUM_DIR];
    q_t pol  [NUM_DIR];
    q_t wt   [NUM_DIR];
    q_t dg   [NUM_DIR];

    // |u|^2 and its 3/2 multiple
    q_t usq;
    q_t c32;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int d = 0; d < NUM_DIR; d++) begin
                proj[d] <= '0;
                sq[d]   <= '0;
                pj2[d]  <= '0;
                a3[d]   <= '0;
                b9[d]   <= '0;
                pol[d]  <= '0;
                wt[d]   <= '0;
                dg[d]   <= '0;
            end
            usq  <= '0;
            c32  <= '0;
            f_eq <= '0;
        end else begin
            // ------------------------------------------------------------
            // Stage 1, lattice vector dotted with u
            // ------------------------------------------------------------
            proj[D_NULL] <= '0;
            proj[D_N]    <= u_y_v;
            proj[D_NE]   <= u_x_v + u_y_v;
            proj[D_E]    <= u_x_v;
            proj[D_SE]   <= u_x_v - u_y_v;
            proj[D_S]    <= -u_y_v;
            proj[D_SW]   <= -(u_x_v + u_y_v);
            proj[D_W]    <= -u_x_v;
            proj[D_NW]   <= u_y_v - u_x_v;

            // Stage 2 squares, stage 3 scaled terms
            usq <= q_mul(proj[D_E], proj[D_E]) + q_mul(proj[D_N], proj[D_N]);
            c32 <= q_mul(Q_THREE_HALVES, usq);

            for (int d = 0; d < NUM_DIR; d++) begin
                sq[d]  <= q_mul(proj[d], proj[d]);
                pj2[d] <= proj[d];
                a3[d]  <= q_mul(Q_THREE, pj2[d]);
                // 9/2 (e.u)^2 as 9/4 times twice the square
                b9[d]  <= q_mul(Q_NINE_QUARTERS, sq[d] <<< 1);

                if (DIAG_MASK[d]) begin
                    // Diagonals finish the polynomial at stage 6, weighted at stage 7
                    pol[d]  <= a3[d] + b9[d] - c32;
                    wt[d]   <= pol[d];
                    dg[d]   <= Q_ONE + wt[d];
                    f_eq[d] <= q_mul(W_DIAG, dg[d]);
                end else begin
                    // Axis and rest directions, weighted at stage 5 then held
                    pol[d]  <= Q_ONE + a3[d] + b9[d] - c32;
                    wt[d]   <= q_mul((d == D_NULL) ? W_NULL : W_SIDE, pol[d]);
                    dg[d]   <= wt[d];
                    f_eq[d] <= dg[d];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lbm_relax.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbm_relax
    import lbm_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  q_t       omega_d,
    input  pop_vec_t f_d,
    input  pop_vec_t f_eq,
    output pop_vec_t f_new
);

    // omega * (f_eq - f) in Q.26
    wide_t delta [NUM_DIR];

    // Population held alongside its delta
    q_t f_h [NUM_DIR];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int d = 0; d < NUM_DIR; d++) begin
                delta[d] <= '0;
                f_h[d]   <= '0;
            end
            f_new <= '0;
        end else begin
            for (int d = 0; d < NUM_DIR; d++) begin
                // f_eq and f already share the Q3.13 scale
                delta[d] <= omega_d * ($signed(f_eq[d]) - $signed(f_d[d]));
                f_h[d]   <= f_d[d];

                // BGK update
                f_new[d] <= f_h[d] + q_t'(delta[d] >>> FRAC_BITS);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lbm_collider.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbm_collider
    import lbm_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  q_t       omega,
    input  pop_vec_t f_in,
    output pop_vec_t f_new,
    output q_t       rho,
    output q_t       u_x,
    output q_t       u_y
);

    q_t       rho_m;
    wide_t    mom_x;
    wide_t    mom_y;
    pop_vec_t f_m;
    q_t       u_x_v;
    q_t       u_y_v;
    pop_vec_t f_eq;
    pop_vec_t f_d;
    q_t       omega_d;

    logic [2*$bits(q_t)-1:0] u_pair;

    // ------------------------------------------------------------
    // Collision datapath
    // ------------------------------------------------------------
    lbm_moments i_moments (
        .clk   (clk),
        .rst   (rst),
        .f_in  (f_in),
        .rho_m (rho_m),
        .mom_x (mom_x),
        .mom_y (mom_y),
        .f_m   (f_m)
    );

    lbm_velocity i_velocity (
        .clk   (clk),
        .rst   (rst),
        .rho_m (rho_m),
        .mom_x (mom_x),
        .mom_y (mom_y),
        .u_x_v (u_x_v),
        .u_y_v (u_y_v)
    );

    lbm_equilibrium i_equilibrium (
        .clk   (clk),
        .rst   (rst),
        .u_x_v (u_x_v),
        .u_y_v (u_y_v),
        .f_eq  (f_eq)
    );

    lbm_relax i_relax (
        .clk     (clk),
        .rst     (rst),
        .omega_d (omega_d),
        .f_d     (f_d),
        .f_eq    (f_eq),
        .f_new   (f_new)
    );

    // ------------------------------------------------------------
    // Alignment delay lines
    // ------------------------------------------------------------
    lbm_delay #(
        .DEPTH (LAT_VELOCITY + LAT_EQUILIBRIUM),
        .WIDTH ($bits(pop_vec_t))
    ) i_dly_pop (
        .clk (clk),
        .rst (rst),
        .d   (f_m),
        .q   (f_d)
    );

    // Omega enters raw, so it also covers the moments stage
    lbm_delay #(
        .DEPTH (LAT_MOMENTS + LAT_VELOCITY + LAT_EQUILIBRIUM),
        .WIDTH ($bits(q_t))
    ) i_dly_omega (
        .clk (clk),
        .rst (rst),
        .d   (omega),
        .q   (omega_d)
    );

    lbm_delay #(
        .DEPTH (LAT_VELOCITY + LAT_EQUILIBRIUM + LAT_RELAX),
        .WIDTH ($bits(q_t))
    ) i_dly_rho (
        .clk (clk),
        .rst (rst),
        .d   (rho_m),
        .q   (rho)
    );

    lbm_delay #(
        .DEPTH (LAT_EQUILIBRIUM + LAT_RELAX),
        .WIDTH (2 * $bits(q_t))
    ) i_dly_vel (
        .clk (clk),
        .rst (rst),
        .d   ({u_x_v, u_y_v}),
        .q   (u_pair)
    );

    assign {u_x, u_y} = u_pair;

endmodule

`default_nettype wire

// ==== bench/tb_lbm_collider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lbm_collider
    import lbm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;
    localparam int NUM_RANDOM     = 40;

    typedef enum logic [2:0] {
        K_NONE, K_ZERO, K_DENSITY, K_IDENT, K_REST, K_VEL
    } kind_e;

    logic     clk;
    logic     rst;
    q_t       omega;
    pop_vec_t f_in;
    pop_vec_t f_new;
    q_t       rho;
    q_t       u_x;
    q_t       u_y;
    kind_e    kind_drv;

    // Items in flight with one entry per clock
    pop_vec_t f_q [$];
    q_t       omega_q [$];
    kind_e    kind_q [$];
    int       pending    = 0;
    int       pops       = 0;
    int       pass_count = 0;
    int       fail_count = 0;

    // Lattice vectors in direction order null, n, ne, e, se, s, sw, w, nw
    int ex [9] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    int ey [9] = '{0, 1, 1, 0, -1, -1, -1, 0, 1};

    lbm_collider i_dut (
        .clk   (clk),
        .rst   (rst),
        .omega (omega),
        .f_in  (f_in),
        .f_new (f_new),
        .rho   (rho),
        .u_x   (u_x),
        .u_y   (u_y)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference helpers
    // ------------------------------------------------------------
    function automatic int as_int(logic [15:0] x);
        return int'($signed(x));
    endfunction

    function automatic real lattice_weight(int d);
        if (d == 0) begin
            return 4.0 / 9.0;
        end else if (d % 2 == 1) begin
            return 1.0 / 9.0;
        end
        return 1.0 / 36.0;
    endfunction

    // Equilibrium populations for density r and velocity (ux, uy) with a little noise
    function automatic pop_vec_t equilibrium_set(real r, real ux, real uy);
        pop_vec_t p;
        real      eu;
        real      v;
        for (int d = 0; d < 9; d++) begin
            eu = ex[d] * ux + ey[d] * uy;
            v  = lattice_weight(d) * r
               * (1.0 + 3.0 * eu + 4.5 * eu * eu - 1.5 * (ux * ux + uy * uy));
            p[d] = q_t'($rtoi(v * 8192.0 + 0.5) + int'($urandom % 17) - 8);
        end
        return p;
    endfunction

    task automatic check_equal(string name, logic [15:0] got, logic [15:0] expected);
        assert (got === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_near(string name, int got, real expected, int tol);
        real diff;
        diff = $itor(got) - expected;
        if (diff < 0.0) begin
            diff = -diff;
        end
        assert (diff <= $itor(tol)) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("CHECK FAILED %s: got %h, expected %h within %0d LSB",
                     name, got, $rtoi(expected), tol);
        end
    endtask

    task automatic check_zero();
        check_equal("rho", rho, 16'h0000);
        check_equal("u_x", u_x, 16'h0000);
        check_equal("u_y", u_y, 16'h0000);
        for (int d = 0; d < 9; d++) begin
            check_equal($sformatf("f_new[%0d]", d), f_new[d], 16'h0000);
        end
    endtask

    task automatic check_item(pop_vec_t f, q_t w, kind_e k);
        logic [15:0] sum16;
        int          rho_i;
        int          mx;
        int          my;
        int          sum_new;
        sum16   = '0;
        mx      = 0;
        my      = 0;
        sum_new = 0;
        for (int d = 0; d < 9; d++) begin
            sum16   = sum16 + f[d];
            mx      = mx + ex[d] * as_int(f[d]);
            my      = my + ey[d] * as_int(f[d]);
            sum_new = sum_new + as_int(f_new[d]);
        end
        rho_i = as_int(sum16);
        case (k)
            K_ZERO: check_zero();
            K_DENSITY: check_equal("rho", rho, sum16);
            K_IDENT: begin
                check_equal("rho", rho, sum16);
                for (int d = 0; d < 9; d++) begin
                    check_equal($sformatf("f_new[%0d]", d), f_new[d], f[d]);
                end
            end
            K_REST: begin
                for (int d = 0; d < 9; d++) begin
                    check_near($sformatf("f_new[%0d]", d), as_int(f_new[d]),
                               $itor(as_int(f[d])), 4);
                end
                check_near("u_x", as_int(u_x), 0.0, 4);
                check_near("u_y", as_int(u_y), 0.0, 4);
            end
            K_VEL: begin
                check_near("u_x", as_int(u_x), $itor(mx) * 8192.0 / $itor(rho_i), 8);
                check_near("u_y", as_int(u_y), $itor(my) * 8192.0 / $itor(rho_i), 8);
                // Mass relaxes toward the reference density of 1.0
                check_near("sum of f_new", sum_new,
                           $itor(rho_i) + $itor(as_int(w)) * $itor(8192 - rho_i) / 8192.0, 16);
            end
            default: ;
        endcase
    endtask

    // Outputs are read at the falling edge 17 entries after their inputs
    always @(negedge clk) begin : monitor
        kind_e k;
        k = rst ? K_ZERO : kind_drv;
        f_q.push_back(f_in);
        omega_q.push_back(omega);
        kind_q.push_back(k);
        if (k != K_NONE && k != K_ZERO) begin
            pending++;
        end
        if (kind_q.size() > LAT_TOTAL) begin
            if (kind_q[0] != K_NONE && kind_q[0] != K_ZERO) begin
                pending--;
            end
            check_item(f_q.pop_front(), omega_q.pop_front(), kind_q.pop_front());
            pops++;
        end else begin
            // Pipeline still holds reset values
            check_zero();
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic apply_item(pop_vec_t f, q_t w, kind_e k);
        @(posedge clk);
        f_in     <= f;
        omega    <= w;
        kind_drv <= k;
    endtask

    task automatic report_test(string name, int pass0, int fail0);
        $display("%s: %0d checks passed, %0d failed",
                 name, pass_count - pass0, fail_count - fail0);
    endtask

    task automatic drain(string name, int pass0, int fail0);
        int cycles;
        apply_item('0, '0, K_NONE);
        cycles = 0;
        while (pending != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (pending != 0) begin
            fail_count++;
            $display("%s: timed out waiting for %0d results", name, pending);
        end
        report_test(name, pass0, fail0);
    endtask

    initial begin
        int       p0;
        int       f0;
        int       cycles;
        real      r;
        real      ux;
        real      uy;
        pop_vec_t f;
        void'($urandom(32'h382b_ba87));
        for (int d = 0; d < 9; d++) begin
            f[d] = q_t'($urandom);
        end

        // Live inputs through reset and fill, the outputs must still read zero
        rst      = 1'b1;
        f_in     = f;
        omega    = q_t'($urandom);
        kind_drv = K_NONE;
        p0       = 0;
        f0       = 0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (pops < LAT_TOTAL && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (pops < LAT_TOTAL) begin
            fail_count++;
            $display("reset: pipeline never filled after reset");
        end
        report_test("reset", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            for (int d = 0; d < 9; d++) begin
                f[d] = q_t'($urandom);
            end
            apply_item(f, q_t'($urandom), K_DENSITY);
        end
        drain("density", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            for (int d = 0; d < 9; d++) begin
                f[d] = q_t'($urandom);
            end
            apply_item(f, '0, K_IDENT);
        end
        drain("no relaxation", p0, f0);

        // Populations at the lattice weights are already in equilibrium
        p0 = pass_count;
        f0 = fail_count;
        for (int d = 0; d < 9; d++) begin
            f[d] = (d == 0) ? W_NULL : ((d % 2 == 1) ? W_SIDE : W_DIAG);
        end
        repeat (8) apply_item(f, Q_ONE, K_REST);
        drain("rest state", p0, f0);

        p0 = pass_count;
        f0 = fail_count;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r  = 0.9 + 0.2 * $itor($urandom % 1001) / 1000.0;
            ux = 0.1 * $itor($urandom % 1001) / 1000.0 - 0.05;
            uy = 0.1 * $itor($urandom % 1001) / 1000.0 - 0.05;
            apply_item(equilibrium_set(r, ux, uy), q_t'(4096 + $urandom % 11469), K_VEL);
        end
        drain("velocity", p0, f0);

        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/lbm_pkg.sv
logic/lbm_delay.sv
logic/lbm_moments.sv
logic/lbm_velocity.sv
logic/lbm_equilibrium.sv
logic/lbm_relax.sv
logic/lbm_collider.sv
bench/tb_lbm_collider.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the collider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_lbm_collider
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_lbm_collider)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
